/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// data word, instruction word and pc all share one width
	typedef logic [15:0] word_t;
	typedef logic [2:0]  reg_addr_t;
	typedef logic [3:0]  opcode_t;
	typedef logic [1:0]  alu_op_t;
	typedef logic [1:0]  fwd_sel_t;

	// opcodes, top nibble of the instruction
	localparam opcode_t OP_ADD  = 4'b0000;
	localparam opcode_t OP_ADI  = 4'b0001;
	localparam opcode_t OP_NAND = 4'b0010;
	localparam opcode_t OP_LHI  = 4'b0011;
	localparam opcode_t OP_LW   = 4'b0100;
	localparam opcode_t OP_SW   = 4'b0101;
	localparam opcode_t OP_NOP  = 4'b0111;
	localparam opcode_t OP_BEQ  = 4'b1000;
	localparam opcode_t OP_JAL  = 4'b1001;

	// bubble word pushed into flushed or stalled slots
	localparam word_t NOP_INSTR = {OP_NOP, 12'h000};

	// both memories use the low bits of a word as address
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;
	localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
	localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

	// alu functions
	localparam alu_op_t ALU_ADD    = 2'd0;
	localparam alu_op_t ALU_NAND   = 2'd1;
	localparam alu_op_t ALU_PASS_B = 2'd2;

	// operand sources in decode, youngest write wins
	localparam fwd_sel_t FWD_RF  = 2'd0;
	localparam fwd_sel_t FWD_EX  = 2'd1;
	localparam fwd_sel_t FWD_MEM = 2'd2;
	localparam fwd_sel_t FWD_WB  = 2'd3;

	// pending register write
	typedef struct packed {
		logic      we;
		reg_addr_t addr;
		word_t     data;
	} dest_t;

	typedef struct packed {
		word_t pc;
		word_t pc_plus1;
		word_t instr;
	} ifid_t;

	typedef struct packed {
		word_t     pc;
		word_t     opa;
		word_t     opb;
		word_t     instr;
		alu_op_t   alu_op;
		logic      imm_sel;
		logic      reg_write;
		logic      mem_write;
		logic      mem_to_reg;
		logic      link;
		reg_addr_t rd;
	} idex_t;

	typedef struct packed {
		dest_t dest;
		word_t store_data;
		word_t addr;
		logic  mem_write;
		logic  mem_to_reg;
	} exmem_t;

	typedef struct packed {
		logic  valid;
		word_t target;
	} redirect_t;

endpackage

`default_nettype wire

/* decode_stage.sv */
`default_nettype none

module decode_stage (
	input  wire                     clk,
	input  wire                     rst,
	input  wire cpu_pkg::ifid_t     ifid,
	input  wire                     stall,
	input  wire                     flush,
	input  wire cpu_pkg::fwd_sel_t  rs1_sel,
	input  wire cpu_pkg::fwd_sel_t  rs2_sel,
	input  wire cpu_pkg::dest_t     ex_dest,
	input  wire cpu_pkg::dest_t     mem_dest,
	input  wire cpu_pkg::dest_t     wb,
	output cpu_pkg::reg_addr_t      rs1,
	output cpu_pkg::reg_addr_t      rs2,
	output logic                    rs1_used,
	output logic                    rs2_used,
	output cpu_pkg::redirect_t      jump_redirect,
	output cpu_pkg::idex_t          idex
);
	import cpu_pkg::*;

	opcode_t   opcode;
	word_t     rd1;
	word_t     rd2;
	word_t     opa_fwd;
	word_t     opa;
	word_t     opb;
	alu_op_t   alu_op;
	logic      imm_sel;
	logic      reg_write;
	logic      mem_write;
	logic      mem_to_reg;
	logic      link;
	reg_addr_t rd;

	// forwarding mux, one per operand
	function automatic word_t fwd_pick(input fwd_sel_t sel, input word_t rf_data,
		input word_t ex_data, input word_t mem_data, input word_t wb_data);
		case (sel)
			FWD_EX:  return ex_data;
			FWD_MEM: return mem_data;
			FWD_WB:  return wb_data;
			default: return rf_data;
		endcase
	endfunction

	register_file i_register_file (
		.clk (clk),
		.rst (rst),
		.rs1 (rs1),
		.rs2 (rs2),
		.wb  (wb),
		.rd1 (rd1),
		.rd2 (rd2)
	);

	assign opcode = ifid.instr[15:12];

	// field decode, defaults suit add/nand/beq
	always_comb begin
		rs1        = ifid.instr[11:9];
		rs2        = ifid.instr[8:6];
		rs1_used   = 1'b0;
		rs2_used   = 1'b0;
		rd         = ifid.instr[11:9];
		alu_op     = ALU_ADD;
		imm_sel    = 1'b0;
		reg_write  = 1'b0;
		mem_write  = 1'b0;
		mem_to_reg = 1'b0;
		link       = 1'b0;
		case (opcode)
			OP_ADD, OP_NAND: begin
				rs1_used  = 1'b1;
				rs2_used  = 1'b1;
				rd        = ifid.instr[5:3];
				reg_write = 1'b1;
				alu_op    = (opcode == OP_NAND) ? ALU_NAND : ALU_ADD;
			end
			OP_ADI: begin
				rs1_used  = 1'b1;
				rd        = ifid.instr[8:6];
				imm_sel   = 1'b1;
				reg_write = 1'b1;
			end
			// lhi value is built in execute and passed through the alu
			OP_LHI: begin
				alu_op    = ALU_PASS_B;
				reg_write = 1'b1;
			end
			// base register rb goes on port 1 for both memory ops
			OP_LW: begin
				rs1        = ifid.instr[8:6];
				rs1_used   = 1'b1;
				imm_sel    = 1'b1;
				reg_write  = 1'b1;
				mem_to_reg = 1'b1;
			end
			OP_SW: begin
				rs1       = ifid.instr[8:6];
				rs2       = ifid.instr[11:9];
				rs1_used  = 1'b1;
				rs2_used  = 1'b1;
				imm_sel   = 1'b1;
				mem_write = 1'b1;
			end
			OP_BEQ: begin
				rs1_used = 1'b1;
				rs2_used = 1'b1;
			end
			OP_JAL: begin
				reg_write = 1'b1;
				link      = 1'b1;
			end
			default: ;
		endcase
	end

	assign opa_fwd = fwd_pick(rs1_sel, rd1, ex_dest.data, mem_dest.data, wb.data);
	assign opb     = fwd_pick(rs2_sel, rd2, ex_dest.data, mem_dest.data, wb.data);
	// jal carries its link value down in operand a
	assign opa = link ? ifid.pc_plus1 : opa_fwd;

	// jal target, pc plus sign-extended imm9
	assign jump_redirect = '{valid: link,
		target: ifid.pc + {{7{ifid.instr[8]}}, ifid.instr[8:0]}};

	always_ff @(posedge clk) begin
		if (rst || stall || flush) begin
			idex       <= '0;
			idex.instr <= NOP_INSTR;
		end else begin
			idex <= '{pc: ifid.pc, opa: opa, opb: opb, instr: ifid.instr,
				alu_op: alu_op, imm_sel: imm_sel, reg_write: reg_write,
				mem_write: mem_write, mem_to_reg: mem_to_reg, link: link, rd: rd};
		end
	end

endmodule

`default_nettype wire

/* execute_stage.sv */
`default_nettype none

module execute_stage (
	input  wire                 clk,
	input  wire                 rst,
	input  wire cpu_pkg::idex_t idex,
	output cpu_pkg::dest_t      ex_dest,
	output logic                ex_is_load,
	output cpu_pkg::redirect_t  branch_redirect,
	output cpu_pkg::exmem_t     exmem
);
	import cpu_pkg::*;

	opcode_t opcode;
	word_t   imm6;
	word_t   lhi_data;
	word_t   offset;
	word_t   alu_b;
	word_t   alu_out;
	word_t   result;
	logic    equal;

	assign opcode = idex.instr[15:12];

	// zero-extended imm6 for adi and address calc
	assign imm6 = {10'b0, idex.instr[5:0]};
	// imm9 into the upper bits
	assign lhi_data = {idex.instr[8:0], 7'b0};
	// beq offset is signed
	assign offset = {{10{idex.instr[5]}}, idex.instr[5:0]};

	// operand b choice
	always_comb begin
		if (opcode == OP_LHI) begin
			alu_b = lhi_data;
		end else if (idex.imm_sel) begin
			alu_b = imm6;
		end else begin
			alu_b = idex.opb;
		end
	end

	always_comb begin
		case (idex.alu_op)
			ALU_NAND:   alu_out = ~(idex.opa & alu_b);
			ALU_PASS_B: alu_out = alu_b;
			default:    alu_out = idex.opa + alu_b;
		endcase
	end

	// link value rides in operand a
	assign result = idex.link ? idex.opa : alu_out;

	// for a load this data is the address, the stall hides it
	assign ex_dest    = '{we: idex.reg_write, addr: idex.rd, data: result};
	assign ex_is_load = idex.mem_to_reg;

	// static not-taken, redirect only when equal
	assign equal = (idex.opa == idex.opb);
	assign branch_redirect = '{valid: (opcode == OP_BEQ) && equal,
		target: idex.pc + offset};

	// ex/mem, address is rb plus imm from the alu
	always_ff @(posedge clk) begin
		if (rst) begin
			exmem <= '0;
		end else begin
			exmem <= '{dest: ex_dest, store_data: idex.opb, addr: alu_out,
				mem_write: idex.mem_write, mem_to_reg: idex.mem_to_reg};
		end
	end

endmodule

`default_nettype wire

/* fetch_stage.sv */
`default_nettype none

module fetch_stage (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  imem_we,
	input  wire cpu_pkg::word_t  imem_addr,
	input  wire cpu_pkg::word_t  imem_data,
	input  wire                  stall,
	input  wire cpu_pkg::redirect_t jump_redirect,
	input  wire cpu_pkg::redirect_t branch_redirect,
	output cpu_pkg::ifid_t       ifid
);
	import cpu_pkg::*;

	word_t pc;
	word_t pc_plus1;
	word_t pc_next;
	word_t instr;
	word_t imem [IMEM_DEPTH];

	assign pc_plus1 = pc + 16'd1;
	// asynchronous instruction read
	assign instr = imem[pc[IMEM_AW-1:0]];

	// load port, honoured only during reset
	always_ff @(posedge clk) begin
		if (rst && imem_we) begin
			imem[imem_addr[IMEM_AW-1:0]] <= imem_data;
		end
	end

	// branch beats stall, stall beats jump
	always_comb begin
		if (branch_redirect.valid) begin
			pc_next = branch_redirect.target;
		end else if (stall) begin
			pc_next = pc;
		end else if (jump_redirect.valid) begin
			pc_next = jump_redirect.target;
		end else begin
			pc_next = pc_plus1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	// if/id, killed on any redirect and frozen on stall
	always_ff @(posedge clk) begin
		if (rst || branch_redirect.valid || jump_redirect.valid) begin
			ifid       <= '0;
			ifid.instr <= NOP_INSTR;
		end else if (!stall) begin
			ifid <= '{pc: pc, pc_plus1: pc_plus1, instr: instr};
		end
	end

	// a jal never sits in decode behind a load-use stall
	a_no_jump_on_stall: assert property (@(posedge clk) disable iff (rst)
		!(stall && jump_redirect.valid && !branch_redirect.valid))
		else $error("jump redirect raised during a load-use stall");

endmodule

`default_nettype wire

/* hazard_unit.sv */
`default_nettype none

module hazard_unit (
	input  wire                     clk,
	input  wire                     rst,
	input  wire cpu_pkg::reg_addr_t rs1,
	input  wire cpu_pkg::reg_addr_t rs2,
	input  wire                     rs1_used,
	input  wire                     rs2_used,
	input  wire cpu_pkg::dest_t     ex_dest,
	input  wire                     ex_is_load,
	input  wire cpu_pkg::dest_t     mem_dest,
	input  wire cpu_pkg::dest_t     wb,
	output cpu_pkg::fwd_sel_t       rs1_sel,
	output cpu_pkg::fwd_sel_t       rs2_sel,
	output logic                    stall
);
	import cpu_pkg::*;

	logic ex_hit1;
	logic ex_hit2;

	// youngest matching write, execute first
	function automatic fwd_sel_t pick_src(input reg_addr_t rs, input dest_t ex_w,
		input dest_t mem_w, input dest_t wb_w);
		if (ex_w.we && ex_w.addr == rs) begin
			return FWD_EX;
		end else if (mem_w.we && mem_w.addr == rs) begin
			return FWD_MEM;
		end else if (wb_w.we && wb_w.addr == rs) begin
			return FWD_WB;
		end
		return FWD_RF;
	endfunction

	assign rs1_sel = pick_src(rs1, ex_dest, mem_dest, wb);
	assign rs2_sel = pick_src(rs2, ex_dest, mem_dest, wb);

	assign ex_hit1 = rs1_used && ex_dest.we && (ex_dest.addr == rs1);
	assign ex_hit2 = rs2_used && ex_dest.we && (ex_dest.addr == rs2);

	// load data only exists after memory, so hold decode one cycle
	assign stall = ex_is_load && (ex_hit1 || ex_hit2);

	// the bubble behind a stall can never be a load
	a_single_stall: assert property (@(posedge clk) disable iff (rst)
		stall |=> !stall)
		else $error("load-use stall held for two cycles");

endmodule

`default_nettype wire

/* memory_stage.sv */
`default_nettype none

module memory_stage (
	input  wire                  clk,
	input  wire                  rst,
	input  wire cpu_pkg::exmem_t exmem,
	output cpu_pkg::dest_t       mem_dest,
	output cpu_pkg::dest_t       wb
);
	import cpu_pkg::*;

	word_t dmem [DMEM_DEPTH];
	word_t load_data;

	// combinational read, registered at mem/wb
	assign load_data = dmem[exmem.addr[DMEM_AW-1:0]];

	// loads swap in memory data, everything else keeps its result
	always_comb begin
		mem_dest = exmem.dest;
		if (exmem.mem_to_reg) begin
			mem_dest.data = load_data;
		end
	end

	// data memory reads zero after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (exmem.mem_write) begin
			dmem[exmem.addr[DMEM_AW-1:0]] <= exmem.store_data;
		end
	end

	// mem/wb, also the write port of the register file
	always_ff @(posedge clk) begin
		if (rst) begin
			wb <= '0;
		end else begin
			wb <= mem_dest;
		end
	end

endmodule

`default_nettype wire

/* pipeline_cpu.sv */
`default_nettype none

module pipeline_cpu (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 imem_we,
	input  wire cpu_pkg::word_t imem_addr,
	input  wire cpu_pkg::word_t imem_data,
	output cpu_pkg::dest_t      wb
);
	import cpu_pkg::*;

	ifid_t     ifid;
	idex_t     idex;
	exmem_t    exmem;
	dest_t     ex_dest;
	dest_t     mem_dest;
	redirect_t jump_redirect;
	redirect_t branch_redirect;
	reg_addr_t rs1;
	reg_addr_t rs2;
	logic      rs1_used;
	logic      rs2_used;
	fwd_sel_t  rs1_sel;
	fwd_sel_t  rs2_sel;
	logic      stall;
	logic      ex_is_load;

	fetch_stage i_fetch_stage (
		.clk             (clk),
		.rst             (rst),
		.imem_we         (imem_we),
		.imem_addr       (imem_addr),
		.imem_data       (imem_data),
		.stall           (stall),
		.jump_redirect   (jump_redirect),
		.branch_redirect (branch_redirect),
		.ifid            (ifid)
	);

	// a taken branch also kills the instruction in decode
	decode_stage i_decode_stage (
		.clk           (clk),
		.rst           (rst),
		.ifid          (ifid),
		.stall         (stall),
		.flush         (branch_redirect.valid),
		.rs1_sel       (rs1_sel),
		.rs2_sel       (rs2_sel),
		.ex_dest       (ex_dest),
		.mem_dest      (mem_dest),
		.wb            (wb),
		.rs1           (rs1),
		.rs2           (rs2),
		.rs1_used      (rs1_used),
		.rs2_used      (rs2_used),
		.jump_redirect (jump_redirect),
		.idex          (idex)
	);

	hazard_unit i_hazard_unit (
		.clk        (clk),
		.rst        (rst),
		.rs1        (rs1),
		.rs2        (rs2),
		.rs1_used   (rs1_used),
		.rs2_used   (rs2_used),
		.ex_dest    (ex_dest),
		.ex_is_load (ex_is_load),
		.mem_dest   (mem_dest),
		.wb         (wb),
		.rs1_sel    (rs1_sel),
		.rs2_sel    (rs2_sel),
		.stall      (stall)
	);

	execute_stage i_execute_stage (
		.clk             (clk),
		.rst             (rst),
		.idex            (idex),
		.ex_dest         (ex_dest),
		.ex_is_load      (ex_is_load),
		.branch_redirect (branch_redirect),
		.exmem           (exmem)
	);

	memory_stage i_memory_stage (
		.clk      (clk),
		.rst      (rst),
		.exmem    (exmem),
		.mem_dest (mem_dest),
		.wb       (wb)
	);

endmodule

`default_nettype wire

/* register_file.sv */
`default_nettype none

module register_file (
	input  wire                     clk,
	input  wire                     rst,
	input  wire cpu_pkg::reg_addr_t rs1,
	input  wire cpu_pkg::reg_addr_t rs2,
	input  wire cpu_pkg::dest_t     wb,
	output cpu_pkg::word_t          rd1,
	output cpu_pkg::word_t          rd2
);
	import cpu_pkg::*;

	word_t regs [8];

	// asynchronous reads, no internal bypass
	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// whatever the pipeline delivers must be resolved data
	a_wb_data_known: assert property (@(posedge clk) disable iff (rst)
		wb.we |-> !$isunknown({wb.addr, wb.data}))
		else $error("register write with unknown address or data");

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
cpu_pkg.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
pipeline_cpu.sv
tb_pipeline_cpu.sv

/* tb_isa_model.svh */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

	localparam int PROG_LEN = 16;
	localparam logic [15:0] LFSR_SEED = 16'd44;

	logic [15:0] lfsr_state;
	word_t       prog [PROG_LEN];

	// expected register writes in program order
	reg_addr_t exp_addr [$];
	word_t     exp_data [$];
	string     exp_name [$];

	// fibonacci lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one step per bit taken and the new bit enters at the lsb
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// three-register format
	function automatic word_t enc_r(input opcode_t op, input reg_addr_t ra,
		input reg_addr_t rb, input reg_addr_t rc);
		return {op, ra, rb, rc, 3'b000};
	endfunction

	// two registers and a 6-bit immediate
	function automatic word_t enc_i(input opcode_t op, input reg_addr_t ra,
		input reg_addr_t rb, input logic [5:0] imm);
		return {op, ra, rb, imm};
	endfunction

	// one register and a 9-bit immediate
	function automatic word_t enc_j(input opcode_t op, input reg_addr_t ra,
		input logic [8:0] imm);
		return {op, ra, imm};
	endfunction

	// add adi nand or lhi on r0..r3 so that results get reused often
	function automatic word_t random_alu();
		logic [1:0] kind;
		reg_addr_t  ra;
		reg_addr_t  rb;
		reg_addr_t  rc;
		logic [8:0] imm;
		kind = 2'(take_bits(2));
		ra = reg_addr_t'(take_bits(2));
		rb = reg_addr_t'(take_bits(2));
		rc = reg_addr_t'(take_bits(2));
		imm = 9'(take_bits(9));
		case (kind)
			2'd0:    return enc_r(OP_ADD, ra, rb, rc);
			2'd1:    return enc_i(OP_ADI, ra, rb, imm[5:0]);
			2'd2:    return enc_r(OP_NAND, ra, rb, rc);
			default: return enc_j(OP_LHI, ra, imm);
		endcase
	endfunction

	task automatic build_program();
		reg_addr_t  base;
		reg_addr_t  a;
		reg_addr_t  c;
		reg_addr_t  s;
		logic [5:0] imm;
		lfsr_state = LFSR_SEED;
		for (int i = 0; i < 4; i++) begin
			prog[i] = random_alu();
		end
		// store then load the same word and use it in the very next slot
		base = reg_addr_t'(take_bits(2));
		imm = 6'(take_bits(6));
		s = reg_addr_t'(take_bits(2));
		prog[4] = enc_i(OP_SW, s, base, imm);
		a = reg_addr_t'(take_bits(3));
		prog[5] = enc_i(OP_LW, a, base, imm);
		s = reg_addr_t'(take_bits(2));
		c = reg_addr_t'(take_bits(2));
		prog[6] = enc_r(OP_ADD, a, s, c);
		// odd immediate so rc never equals ra afterwards
		a = reg_addr_t'(take_bits(3));
		c = a + 3'd1 + reg_addr_t'(take_bits(2));
		imm = {5'(take_bits(5)), 1'b1};
		prog[7] = enc_i(OP_ADI, a, c, imm);
		// taken beq skips slots 9 and 10
		s = reg_addr_t'(take_bits(3));
		prog[8] = enc_i(OP_BEQ, s, s, 6'd3);
		prog[9] = random_alu();
		prog[10] = random_alu();
		// never taken so slots 12 and 13 retire
		prog[11] = enc_i(OP_BEQ, a, c, 6'd3);
		prog[12] = random_alu();
		s = reg_addr_t'(take_bits(3));
		prog[13] = enc_j(OP_JAL, s, 9'd2);
		prog[14] = random_alu();
		// halt loop
		prog[15] = enc_i(OP_BEQ, 3'd0, 3'd0, 6'd0);
	endtask

	// instruction-level interpreter that records every register write
	task automatic run_model();
		word_t     regs [8];
		word_t     dmem [DMEM_DEPTH];
		word_t     pc;
		word_t     pc_next;
		word_t     ins;
		word_t     addr;
		word_t     wr_data;
		reg_addr_t wr_addr;
		logic      wr_en;
		logic      halted;
		string     mnem;
		int        steps;
		for (int i = 0; i < 8; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < DMEM_DEPTH; i++) begin
			dmem[i] = '0;
		end
		pc = '0;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < 64) begin
			// program is exactly 16 words long
			ins = prog[pc[3:0]];
			pc_next = pc + 16'd1;
			addr = regs[ins[8:6]] + {10'b0, ins[5:0]};
			wr_en = 1'b1;
			wr_addr = ins[5:3];
			wr_data = '0;
			mnem = "";
			case (ins[15:12])
				OP_ADD: begin
					wr_data = regs[ins[11:9]] + regs[ins[8:6]];
					mnem = "add";
				end
				OP_ADI: begin
					wr_addr = ins[8:6];
					wr_data = regs[ins[11:9]] + {10'b0, ins[5:0]};
					mnem = "adi";
				end
				OP_NAND: begin
					wr_data = ~(regs[ins[11:9]] & regs[ins[8:6]]);
					mnem = "nand";
				end
				OP_LHI: begin
					wr_addr = ins[11:9];
					wr_data = {ins[8:0], 7'b0};
					mnem = "lhi";
				end
				OP_LW: begin
					wr_addr = ins[11:9];
					wr_data = dmem[addr[DMEM_AW-1:0]];
					mnem = "lw";
				end
				OP_SW: begin
					wr_en = 1'b0;
					dmem[addr[DMEM_AW-1:0]] = regs[ins[11:9]];
				end
				OP_BEQ: begin
					wr_en = 1'b0;
					if (regs[ins[11:9]] == regs[ins[8:6]]) begin
						// zero offset on itself means halt
						halted = (ins[5:0] == 6'd0);
						pc_next = pc + {{10{ins[5]}}, ins[5:0]};
					end
				end
				OP_JAL: begin
					wr_addr = ins[11:9];
					wr_data = pc + 16'd1;
					pc_next = pc + {{7{ins[8]}}, ins[8:0]};
					mnem = "jal";
				end
				default: wr_en = 1'b0;
			endcase
			if (wr_en) begin
				regs[wr_addr] = wr_data;
				exp_addr.push_back(wr_addr);
				exp_data.push_back(wr_data);
				exp_name.push_back($sformatf("wb%0d_%s_pc%0d", exp_addr.size() - 1,
					mnem, pc));
			end
			pc = pc_next;
			steps++;
		end
	endtask

`endif

/* tb_pipeline_cpu.sv */
`default_nettype none

module tb_pipeline_cpu;
	import cpu_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int RUN_TIMEOUT  = 200;
	localparam int QUIET_CYCLES = 60;

	logic  clk;
	logic  rst;
	logic  imem_we;
	word_t imem_addr;
	word_t imem_data;
	dest_t wb;
	int    seen;

	`include "tb_isa_model.svh"

	pipeline_cpu i_pipeline_cpu (
		.clk       (clk),
		.rst       (rst),
		.imem_we   (imem_we),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.wb        (wb)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// prints the reason and the fail line then ends the run
	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic report_mismatch(input string name, input reg_addr_t exp_a,
		input word_t exp_d, input reg_addr_t got_a, input word_t got_d);
		stop_on_error($sformatf("CHECK FAILED %s expected r%0d=%h actual r%0d=%h",
			name, exp_a, exp_d, got_a, got_d));
	endtask

	// wb monitor sees last cycle's registered value at each rising edge
	always @(posedge clk) begin
		a_no_wb_in_reset: assert (!(rst && wb.we === 1'b1))
			else stop_on_error("a register write appeared on wb while reset was high");
		if (!rst) begin
			a_wb_we_known: assert (!$isunknown(wb.we))
				else stop_on_error("wb write enable is unknown after reset");
			if (wb.we === 1'b1) begin
				// anything beyond the model list is an extra write
				if (seen >= exp_addr.size()) begin
					stop_on_error("a register write arrived after the halt loop was reached");
				end else begin
					a_wb_match: assert (wb.addr == exp_addr[seen] && wb.data == exp_data[seen])
						seen++;
					else report_mismatch(exp_name[seen], exp_addr[seen], exp_data[seen],
						wb.addr, wb.data);
				end
			end
		end
	end

	initial begin
		int cycles;
		clk = 1'b0;
		rst = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		seen = 0;
		build_program();
		run_model();
		// one program word per reset cycle through the load port
		for (int i = 0; i < RESET_CYCLES; i++) begin
			if (i > 0) begin
				@(negedge clk);
			end
			imem_we = (i < PROG_LEN);
			imem_addr = word_t'(i);
			imem_data = (i < PROG_LEN) ? prog[i] : NOP_INSTR;
		end
		@(negedge clk);
		imem_we = 1'b0;
		rst = 1'b0;
		// every modelled write has to show up
		cycles = 0;
		while (seen < exp_addr.size() && cycles < RUN_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (seen < exp_addr.size()) begin
			stop_on_error($sformatf("timeout: only %0d of %0d expected register writes arrived",
				seen, exp_addr.size()));
		end else begin
			// halt loop spinning and the monitor flags any further write
			cycles = 0;
			while (cycles < QUIET_CYCLES) begin
				@(negedge clk);
				cycles++;
			end
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

`default_nettype wire
